//--- Makefile
SIM      := verilator
TOP      := mac_slice_tb
FILELIST := mac_slice.f
VFLAGS   := --binary --timing --assert -Wno-fatal
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := Result: PASSED

SRCS := $(filter %.sv,$(shell cat $(FILELIST))) hw/mac_params.svh

.PHONY: all run check clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

check:
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/mac_slice_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module mac_slice_asserts (
	input wire                     clk,
	input wire                     rst,
	input wire mac_pkg::apb_req_t  apb,
	input wire                     pready,
	input wire                     res_valid,
	input wire mac_pkg::mac_ctl_t  ctl,
	input wire mac_pkg::mac_cfg_t  cfg
);

	// ------------------------------------------------------------------------
	// APB side

	pready_in_access: assert property (@(posedge clk) disable iff (rst)
		(apb.psel && apb.penable) |-> pready)
		else $error("pready low during an APB access phase");

	// ------------------------------------------------------------------------
	// result and control

	// two results in a row need two lasts in a row, 2 cycles earlier
	valid_pairs: assert property (@(posedge clk) disable iff (rst)
		(res_valid && $past(res_valid)) |-> ($past(ctl.last, 2) && $past(ctl.last, 3)))
		else $error("res_valid held for two cycles without two group ends");

	quiet_in_reset: assert property (@(posedge clk)
		(rst && $past(rst)) |-> !res_valid)
		else $error("res_valid high while in reset");

	no_ctl_when_off: assert property (@(posedge clk) disable iff (rst)
		!cfg.enable |-> !ctl.valid)
		else $error("control word issued while disabled");

endmodule

`default_nettype wire

//--- bench/mac_slice_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "mac_params.svh"

module mac_slice_tb;

	logic              clk = 1'b0;
	logic              rst;
	mac_pkg::apb_req_t apb;
	logic [31:0]       prdata;
	logic              pready;
	logic              pslverr;
	mac_pkg::act_t     a_in;
	logic              a_en;
	mac_pkg::act_t     a_cascade;
	mac_pkg::wgt_t     w_in;
	logic              w_en;
	mac_pkg::wgt_t     w_cascade;
	mac_pkg::acc_t     res_out;
	logic              res_valid;

	// reference model
	logic [31:0]       lfsr = 32'h5536_cb5b;
	mac_pkg::act_t     hist[$];      // earlier samples with the newest first
	mac_pkg::wgt_t     wmem[4];
	logic              m_en;
	logic              m_sm;
	logic              m_hp;
	logic              m_high;       // next sample is a high half
	int                m_len;
	int                m_tap;
	int                m_addr;
	int                m_pos;
	int                m_acc;

	// expected results and bookkeeping
	logic              mark_last;
	logic [31:0]       mark_sum;
	mac_pkg::act_t     casc_exp;
	mac_pkg::act_t     casc_prev;
	logic              casc_chk = 1'b0;
	logic [31:0]       exp_q[$];
	int                due_q[$];     // negedge cycle the result is due
	int                cyc = 0;
	int                res_exp = 0;  // group results predicted so far
	logic              reported = 1'b0;

	always #50 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	mac_slice UUT (
		.clk       (clk),
		.rst       (rst),
		.apb       (apb),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.a_in      (a_in),
		.a_en      (a_en),
		.a_cascade (a_cascade),
		.w_in      (w_in),
		.w_en      (w_en),
		.w_cascade (w_cascade),
		.res_out   (res_out),
		.res_valid (res_valid)
	);

	bind mac_slice mac_slice_asserts u_asserts (
		.clk(clk), .rst(rst), .apb(apb), .pready(pready),
		.res_valid(res_valid), .ctl(ctl), .cfg(cfg)
	);

	// ------------------------------------------------------------------------
	// failure handling

	task automatic fail_run();
		reported = 1'b1;
		$display("Result: FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic timed_out(input string what);
		$display("timeout while waiting for %s", what);
		fail_run();
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("ERROR %0t %s expected %h got %h", $time, name, exp, got);
			fail_run();
		end
	endtask

	pslverr_in_access: assert property (@(posedge clk) pslverr |-> (apb.psel && apb.penable))
		else begin
			$display("pslverr high outside an APB access phase");
			fail_run();
		end

	final begin
		if (!reported)
			$display("Result: FAILED");
	end

	// ------------------------------------------------------------------------
	// random numbers

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};  // one step per bit
		end
	endtask

	// ------------------------------------------------------------------------
	// APB

	task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		input logic exp_err, output logic [31:0] rdata);
		int n;
		@(posedge clk);
		apb.psel    <= 1'b1;
		apb.penable <= 1'b0;
		apb.pwrite  <= wr;
		apb.paddr   <= addr;
		apb.pwdata  <= wdata;
		@(posedge clk);
		apb.penable <= 1'b1;
		n = 0;
		@(negedge clk);
		while (!pready) begin
			n++;
			if (n > 16)
				timed_out("pready");
			@(negedge clk);
		end
		check_val("pslverr", pslverr, exp_err);
		rdata = prdata;
		@(posedge clk);
		apb.psel    <= 1'b0;
		apb.penable <= 1'b0;
	endtask

	task automatic reg_write(input logic [7:0] addr, input logic [31:0] data, input logic err);
		logic [31:0] unused;
		apb_access(1'b1, addr, data, err, unused);
		if (!err && addr == `MAC_REG_CTRL) begin
			m_en = data[0];
			m_sm = data[1];
			m_hp = data[2];
			if (!data[0]) begin  // disable restarts the group at address 0
				m_addr = 0;
				m_pos  = 0;
				m_high = 1'b0;
			end
		end
		if (!err && addr == `MAC_REG_LEN)
			m_len = int'(data[3:0]);
		if (!err && addr == `MAC_REG_TAP)
			m_tap = int'(data[1:0]);
	endtask

	task automatic reg_read(input logic [7:0] addr, input logic [31:0] exp, input logic err);
		logic [31:0] rdata;
		apb_access(1'b0, addr, 32'h0, err, rdata);
		if (!err)
			check_val("prdata", rdata, exp);
	endtask

	// ------------------------------------------------------------------------
	// streams and model

	task automatic load_weight(input mac_pkg::wgt_t w);
		mac_pkg::wgt_t casc;
		casc = wmem[3];
		for (int i = 3; i > 0; i--)
			wmem[i] = wmem[i-1];
		wmem[0] = w;
		@(posedge clk);
		w_in <= w;
		w_en <= 1'b1;
		@(posedge clk);
		w_en <= 1'b0;
		@(negedge clk);
		check_val("w_cascade", w_cascade, casc);
	endtask

	task automatic send_sample(input mac_pkg::act_t a);
		mac_pkg::act_t ta;
		mac_pkg::wgt_t w;
		int            av;
		int            wv;
		int            prod;
		int            eff_len;
		logic          last;
		ta = (m_tap == 0) ? a : hist[m_tap-1];
		hist.push_front(a);
		void'(hist.pop_back());
		last = 1'b0;
		eff_len = (m_len == 0) ? 1 : m_len;
		if (m_en) begin
			w  = wmem[m_addr];
			wv = int'(w);
			if (m_sm && w[7])
				wv -= 256;
			av = int'(ta);
			if (m_sm && ta[7] && (!m_hp || m_high))  // low half stays unsigned
				av -= 256;
			prod = av * wv;
			if (m_high)
				prod = prod <<< 8;
			if (m_pos == 0 && !m_high)
				m_acc = prod;
			else
				m_acc += prod;
			if (m_hp && !m_high) begin
				m_high = 1'b1;
			end else begin
				m_high = 1'b0;
				m_addr = (m_addr + 1) % 4;
				m_pos++;
				if (m_pos == eff_len) begin
					last  = 1'b1;
					m_pos = 0;
				end
			end
		end
		@(posedge clk);
		a_in      <= a;
		a_en      <= 1'b1;
		mark_last <= last;
		mark_sum  <= m_acc;
		casc_exp  <= hist[3];
	endtask

	task automatic wait_results();
		int n;
		n = 0;
		while (exp_q.size() != 0) begin
			n++;
			if (n > 20)
				timed_out("res_valid");
			@(negedge clk);
		end
	endtask

	task automatic stream_random(input int count);
		logic [31:0] r;
		repeat (count) begin
			rand_bits(8, r);
			send_sample(r[7:0]);
		end
		@(posedge clk);
		a_en      <= 1'b0;
		mark_last <= 1'b0;
		wait_results();
	endtask

	// result and cascade monitor
	always @(negedge clk) begin
		if (casc_chk)
			check_val("a_cascade", a_cascade, casc_prev);
		casc_chk  = a_en;
		casc_prev = casc_exp;
		if (a_en && mark_last) begin
			exp_q.push_back(mark_sum);
			due_q.push_back(cyc + 2);
			res_exp++;
		end
		if (res_valid) begin
			assert (exp_q.size() != 0) else begin
				$display("res_valid pulsed with no group result pending");
				fail_run();
			end
			check_val("res_valid cycle", cyc, due_q.pop_front());
			check_val("res_out", res_out, exp_q.pop_front());
		end
	end

	// ------------------------------------------------------------------------
	// test sequence

	initial begin
		logic [31:0]   r;
		mac_pkg::wgt_t first_w;
		rst = 1'b1;
		apb = '0;
		a_in = '0;
		a_en = 1'b0;
		w_in = '0;
		w_en = 1'b0;
		mark_last = 1'b0;
		mark_sum = '0;
		casc_exp = '0;
		for (int i = 0; i < 4; i++) begin
			hist.push_back('0);
			wmem[i] = '0;
		end
		m_en = 1'b0;
		m_sm = 1'b0;
		m_hp = 1'b0;
		m_high = 1'b0;
		m_len = 0;
		m_tap = 0;
		m_addr = 0;
		m_pos = 0;
		m_acc = 0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;

		// register access and errors
		reg_write(`MAC_REG_CTRL, 32'h6, 1'b0);
		reg_read(`MAC_REG_CTRL, 32'h6, 1'b0);
		reg_write(`MAC_REG_LEN, 32'h5A, 1'b0);
		reg_read(`MAC_REG_LEN, 32'hA, 1'b0);    // only the 4-bit field
		reg_write(`MAC_REG_TAP, 32'hFF, 1'b0);
		reg_read(`MAC_REG_TAP, 32'h3, 1'b0);
		reg_write(8'h10, 32'h1, 1'b1);
		reg_read(8'h10, 32'h0, 1'b1);
		reg_write(`MAC_REG_COUNT, 32'h55, 1'b1);
		reg_read(`MAC_REG_COUNT, 32'h0, 1'b0);
		reg_read(`MAC_REG_CTRL, 32'h6, 1'b0);

		rand_bits(8, r);
		first_w = r[7:0];
		load_weight(first_w);
		repeat (3) begin
			rand_bits(8, r);
			load_weight(r[7:0]);
		end

		// tap sweep from the deepest tap while the line still holds zeros
		reg_write(`MAC_REG_LEN, 32'h4, 1'b0);
		for (int t = 3; t >= 0; t--) begin
			reg_write(`MAC_REG_CTRL, 32'h0, 1'b0);
			reg_write(`MAC_REG_TAP, t, 1'b0);
			reg_write(`MAC_REG_CTRL, 32'h1, 1'b0);
			stream_random(8);
		end

		// normal mode dot products
		reg_write(`MAC_REG_CTRL, 32'h0, 1'b0);
		reg_write(`MAC_REG_CTRL, 32'h1, 1'b0);
		stream_random(8);
		reg_write(`MAC_REG_CTRL, 32'h3, 1'b0);
		reg_write(`MAC_REG_LEN, 32'h3, 1'b0);
		stream_random(9);

		// high precision unsigned then signed
		reg_write(`MAC_REG_CTRL, 32'h0, 1'b0);
		reg_write(`MAC_REG_LEN, 32'h2, 1'b0);
		reg_write(`MAC_REG_CTRL, 32'h5, 1'b0);
		stream_random(8);
		reg_write(`MAC_REG_CTRL, 32'h0, 1'b0);
		reg_write(`MAC_REG_CTRL, 32'h7, 1'b0);
		stream_random(8);

		// length 1 gives a result for every sample
		reg_write(`MAC_REG_CTRL, 32'h0, 1'b0);
		reg_write(`MAC_REG_LEN, 32'h1, 1'b0);
		reg_write(`MAC_REG_CTRL, 32'h1, 1'b0);
		stream_random(4);

		// back to back groups then stop and restart mid group
		reg_write(`MAC_REG_CTRL, 32'h0, 1'b0);
		reg_write(`MAC_REG_LEN, 32'h5, 1'b0);
		reg_write(`MAC_REG_CTRL, 32'h3, 1'b0);
		stream_random(20);
		stream_random(3);
		reg_write(`MAC_REG_CTRL, 32'h0, 1'b0);
		stream_random(6);
		reg_write(`MAC_REG_CTRL, 32'h3, 1'b0);
		stream_random(5);

		// fifth weight pushes the first one out
		rand_bits(8, r);
		load_weight(r[7:0]);
		check_val("w_cascade", w_cascade, first_w);
		reg_read(`MAC_REG_COUNT, res_exp, 1'b0);

		reported = 1'b1;
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/mac_act_stream.sv
`timescale 1ns/10ps
`default_nettype none
`include "mac_params.svh"

module mac_act_stream (
	input  wire                 clk,
	input  wire                 rst,
	input  wire mac_pkg::act_t  a_in,
	input  wire                 a_en,
	input  wire mac_pkg::tap_t  tap,
	output mac_pkg::act_t       a_tap,
	output mac_pkg::act_t       a_cascade
);

	mac_pkg::act_t stage_q [`MAC_A_DEPTH];
	mac_pkg::act_t tap_line [`MAC_A_DEPTH]; // tap_line[k] is k samples back

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `MAC_A_DEPTH; i++)
				stage_q[i] <= '0;
		end else if (a_en) begin
			stage_q[0] <= a_in;
			for (int i = 1; i < `MAC_A_DEPTH; i++)
				stage_q[i] <= stage_q[i-1];
		end
	end

	always_comb begin
		tap_line[0] = a_in; // tap 0 passes the current sample straight through
		for (int i = 1; i < `MAC_A_DEPTH; i++)
			tap_line[i] = stage_q[i-1];
	end

	assign a_tap     = tap_line[tap];
	assign a_cascade = stage_q[`MAC_A_DEPTH-1];

endmodule

`default_nettype wire

//--- hw/mac_cfg_regs.sv
`timescale 1ns/10ps
`default_nettype none
`include "mac_params.svh"

module mac_cfg_regs (
	input  wire                     clk,
	input  wire                     rst,
	input  wire mac_pkg::apb_req_t  apb,
	output logic [31:0]             prdata,
	output logic                    pready,
	output logic                    pslverr,
	input  wire                     res_valid,
	output mac_pkg::mac_cfg_t       cfg
);

	logic          access;
	logic          hit_ctrl;
	logic          hit_len;
	logic          hit_tap;
	logic          hit_count;
	logic          bad;
	logic [2:0]    ctrl_q;  // hp, signed_mode, enable
	mac_pkg::len_t len_q;
	mac_pkg::tap_t tap_q;
	logic [31:0]   count_q; // results emitted since reset

	// ------------------------------------------------------------------------
	// address decode

	assign access    = apb.psel & apb.penable;
	assign hit_ctrl  = (apb.paddr == `MAC_REG_CTRL);
	assign hit_len   = (apb.paddr == `MAC_REG_LEN);
	assign hit_tap   = (apb.paddr == `MAC_REG_TAP);
	assign hit_count = (apb.paddr == `MAC_REG_COUNT);

	// unmapped, or a write to the read-only counter
	assign bad = ~(hit_ctrl | hit_len | hit_tap | hit_count) | (apb.pwrite & hit_count);

	assign pready  = 1'b1;           // zero wait states
	assign pslverr = access & bad;

	always_ff @(posedge clk) begin
		if (rst) begin
			ctrl_q <= '0;
			len_q  <= '0;
			tap_q  <= '0;
		end else if (access & apb.pwrite & ~bad) begin
			if (hit_ctrl)
				ctrl_q <= apb.pwdata[2:0];
			if (hit_len)
				len_q <= apb.pwdata[`MAC_LEN_W-1:0];
			if (hit_tap)
				tap_q <= apb.pwdata[$bits(mac_pkg::tap_t)-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			count_q <= '0;
		else if (res_valid)
			count_q <= count_q + 32'd1;
	end

	// read mux, zero for anything unmapped
	always_comb begin
		prdata = '0;
		if (hit_ctrl)
			prdata[2:0] = ctrl_q;
		else if (hit_len)
			prdata[`MAC_LEN_W-1:0] = len_q;
		else if (hit_tap)
			prdata[$bits(mac_pkg::tap_t)-1:0] = tap_q;
		else if (hit_count)
			prdata = count_q;
	end

	assign cfg.enable      = ctrl_q[0];
	assign cfg.signed_mode = ctrl_q[1];
	assign cfg.hp          = ctrl_q[2];
	assign cfg.len         = len_q;
	assign cfg.tap         = tap_q;

endmodule

`default_nettype wire

//--- hw/mac_datapath.sv
`timescale 1ns/10ps
`default_nettype none
`include "mac_params.svh"

module mac_datapath (
	input  wire                     clk,
	input  wire                     rst,
	input  wire mac_pkg::act_t      a,
	input  wire mac_pkg::wgt_t      w,
	input  wire mac_pkg::mac_ctl_t  ctl,
	output mac_pkg::acc_t           res_out,
	output logic                    res_valid
);

	localparam int PW = $bits(mac_pkg::prod_t);
	localparam int RW = $bits(mac_pkg::acc_t);

	logic signed [`MAC_ACT_W:0]             a_ext;
	logic signed [`MAC_WGT_W:0]             w_ext;
	logic signed [`MAC_ACT_W+`MAC_WGT_W+1:0] prod_full;
	mac_pkg::prod_t                         prod;
	mac_pkg::acc_t                          prod_ext;
	mac_pkg::acc_t                          p1_q;     // stage 1 shifted product
	logic                                   v1_q;
	logic                                   first1_q;
	logic                                   last1_q;
	mac_pkg::acc_t                          acc_q;
	mac_pkg::acc_t                          sum;

	// ------------------------------------------------------------------------
	// multiply, extension per operand sign

	assign a_ext     = {ctl.a_s & a[`MAC_ACT_W-1], a};
	assign w_ext     = {ctl.b_s & w[`MAC_WGT_W-1], w};
	assign prod_full = a_ext * w_ext;
	assign prod      = prod_full[PW-1:0];
	assign prod_ext  = {{(RW-PW){prod[PW-1]}}, prod};

	// first replaces the running sum
	assign sum = first1_q ? p1_q : acc_q + p1_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			v1_q      <= 1'b0;
			first1_q  <= 1'b0;
			last1_q   <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			v1_q      <= ctl.valid;
			first1_q  <= ctl.first;
			last1_q   <= ctl.last;
			res_valid <= v1_q & last1_q;  // one cycle pulse, no hold
		end
	end

	always_ff @(posedge clk) begin
		p1_q <= ctl.shift_hi ? (prod_ext << `MAC_ACT_W) : prod_ext;
		if (v1_q) begin
			acc_q <= sum;
			if (last1_q)
				res_out <= sum;
		end
	end

endmodule

`default_nettype wire

//--- hw/mac_params.svh
`ifndef MAC_PARAMS_SVH
`define MAC_PARAMS_SVH

// datapath widths
`define MAC_ACT_W     8
`define MAC_WGT_W     8
`define MAC_RES_W     32

// storage depths
`define MAC_W_DEPTH   4
`define MAC_A_DEPTH   4
`define MAC_LEN_W     4   // group length 1..15, 0 acts as 1

// APB register map
`define MAC_APB_AW    8
`define MAC_REG_CTRL  8'h00
`define MAC_REG_LEN   8'h04
`define MAC_REG_TAP   8'h08
`define MAC_REG_COUNT 8'h0C

`endif

//--- hw/mac_pkg.sv
`default_nettype none
`include "mac_params.svh"

package mac_pkg;

	typedef logic [`MAC_ACT_W-1:0]                act_t;
	typedef logic [`MAC_WGT_W-1:0]                wgt_t;
	typedef logic signed [`MAC_ACT_W+`MAC_WGT_W:0] prod_t; // 9x9 signed fits in 17 bits
	typedef logic [`MAC_RES_W-1:0]                acc_t;
	typedef logic [$clog2(`MAC_W_DEPTH)-1:0]      waddr_t;
	typedef logic [$clog2(`MAC_A_DEPTH)-1:0]      tap_t;
	typedef logic [`MAC_LEN_W-1:0]                len_t;

	// ------------------------------------------------------------------------
	// configuration and per-sample control

	typedef struct packed {
		logic enable;
		logic signed_mode;
		logic hp;           // 16-bit activations as two halves
		len_t len;
		tap_t tap;
	} mac_cfg_t;

	typedef struct packed {
		logic valid;
		logic a_s;          // activation operand signed
		logic b_s;          // weight operand signed
		logic shift_hi;     // high half, product << 8
		logic first;
		logic last;
	} mac_ctl_t;

	typedef struct packed {
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [`MAC_APB_AW-1:0] paddr;
		logic [31:0]           pwdata;
	} apb_req_t;

	typedef enum logic [1:0] {
		IDLE,
		LOW,
		HIGH
	} seq_state_t;

endpackage

`default_nettype wire

//--- hw/mac_seq.sv
`timescale 1ns/10ps
`default_nettype none

module mac_seq (
	input  wire                     clk,
	input  wire                     rst,
	input  wire mac_pkg::mac_cfg_t  cfg,
	input  wire                     a_en,
	output mac_pkg::waddr_t         addr,
	output mac_pkg::mac_ctl_t       ctl
);

	mac_pkg::seq_state_t state_q;
	mac_pkg::waddr_t     addr_q;
	mac_pkg::len_t       cnt_q;     // position within the group
	mac_pkg::len_t       last_pos;
	logic                hi_phase;
	logic                pair_done; // this sample closes an address step
	logic                grp_end;

	assign last_pos  = (cfg.len == '0) ? '0 : cfg.len - mac_pkg::len_t'(1);
	assign hi_phase  = cfg.hp & (state_q == mac_pkg::HIGH);
	assign pair_done = ~cfg.hp | hi_phase;
	assign grp_end   = pair_done & (cnt_q == last_pos);

	// ------------------------------------------------------------------------
	// FSM, address and group counters

	always_ff @(posedge clk) begin
		if (rst || !cfg.enable) begin // disable also restarts at address 0
			state_q <= mac_pkg::IDLE;
			addr_q  <= '0;
			cnt_q   <= '0;
		end else if (a_en) begin
			if (pair_done) begin
				state_q <= mac_pkg::LOW;
				addr_q  <= addr_q + mac_pkg::waddr_t'(1);
				cnt_q   <= grp_end ? '0 : cnt_q + mac_pkg::len_t'(1);
			end else begin
				state_q <= mac_pkg::HIGH; // low half taken, same weight next
			end
		end else if (state_q == mac_pkg::IDLE) begin
			state_q <= mac_pkg::LOW;
		end
	end

	assign addr = addr_q;

	assign ctl.valid    = cfg.enable & a_en;
	assign ctl.a_s      = cfg.signed_mode & (~cfg.hp | hi_phase); // low half unsigned
	assign ctl.b_s      = cfg.signed_mode;
	assign ctl.shift_hi = hi_phase;
	assign ctl.first    = ctl.valid & (cnt_q == '0) & ~hi_phase;
	assign ctl.last     = ctl.valid & grp_end;

endmodule

`default_nettype wire

//--- hw/mac_slice.sv
`timescale 1ns/10ps
`default_nettype none

module mac_slice (
	input  wire                     clk,
	input  wire                     rst,
	input  wire mac_pkg::apb_req_t  apb,
	output logic [31:0]             prdata,
	output logic                    pready,
	output logic                    pslverr,
	input  wire mac_pkg::act_t      a_in,
	input  wire                     a_en,
	output mac_pkg::act_t           a_cascade,
	input  wire mac_pkg::wgt_t      w_in,
	input  wire                     w_en,
	output mac_pkg::wgt_t           w_cascade,
	output mac_pkg::acc_t           res_out,
	output logic                    res_valid
);

	mac_pkg::mac_cfg_t cfg;
	mac_pkg::mac_ctl_t ctl;
	mac_pkg::act_t     a_tap;
	mac_pkg::wgt_t     w_rd;
	mac_pkg::waddr_t   addr;

	mac_cfg_regs u_regs (
		.clk       (clk),
		.rst       (rst),
		.apb       (apb),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.res_valid (res_valid),
		.cfg       (cfg)
	);

	mac_act_stream u_act (
		.clk       (clk),
		.rst       (rst),
		.a_in      (a_in),
		.a_en      (a_en),
		.tap       (cfg.tap),
		.a_tap     (a_tap),
		.a_cascade (a_cascade)
	);

	mac_weight_mem u_wgt (
		.clk       (clk),
		.rst       (rst),
		.w_in      (w_in),
		.w_en      (w_en),
		.addr      (addr),
		.w_out     (w_rd),
		.w_cascade (w_cascade)
	);

	mac_seq u_seq (
		.clk  (clk),
		.rst  (rst),
		.cfg  (cfg),
		.a_en (a_en),
		.addr (addr),
		.ctl  (ctl)
	);

	mac_datapath u_dp (
		.clk       (clk),
		.rst       (rst),
		.a         (a_tap),
		.w         (w_rd),
		.ctl       (ctl),
		.res_out   (res_out),
		.res_valid (res_valid)
	);

endmodule

`default_nettype wire

//--- hw/mac_weight_mem.sv
`timescale 1ns/10ps
`default_nettype none
`include "mac_params.svh"

module mac_weight_mem (
	input  wire                  clk,
	input  wire                  rst,
	input  wire mac_pkg::wgt_t   w_in,
	input  wire                  w_en,
	input  wire mac_pkg::waddr_t addr,
	output mac_pkg::wgt_t        w_out,
	output mac_pkg::wgt_t        w_cascade
);

	mac_pkg::wgt_t mem_q [`MAC_W_DEPTH];
	mac_pkg::wgt_t casc_q;

	// ------------------------------------------------------------------------
	// shift load, entry 0 takes the new weight

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `MAC_W_DEPTH; i++)
				mem_q[i] <= '0;
			casc_q <= '0;
		end else if (w_en) begin
			mem_q[0] <= w_in;
			for (int i = 1; i < `MAC_W_DEPTH; i++)
				mem_q[i] <= mem_q[i-1];
			casc_q <= mem_q[`MAC_W_DEPTH-1]; // top entry falls out to the next slice
		end
	end

	assign w_out     = mem_q[addr];
	assign w_cascade = casc_q;

endmodule

`default_nettype wire

//--- mac_slice.f
+incdir+hw
hw/mac_pkg.sv
hw/mac_cfg_regs.sv
hw/mac_act_stream.sv
hw/mac_weight_mem.sv
hw/mac_seq.sv
hw/mac_datapath.sv
hw/mac_slice.sv
bench/mac_slice_asserts.sv
bench/mac_slice_tb.sv
